//--- source/udp_hub_pkg.sv
package udp_hub_pkg;

   // the client slot index doubles as the arbitration priority
   localparam int unsigned num_clients    = 3;
   localparam int unsigned client_dhcp    = 0;
   localparam int unsigned client_control = 1;
   localparam int unsigned client_stream  = 2;

   // udp ports served by the hub
   localparam logic [15:0] dhcp_client_port = 16'd68;
   localparam logic [15:0] control_port     = 16'd18521;
   localparam logic [15:0] stream_port      = 16'd18520;

   typedef enum logic [1:0] {
      tx_idle    = 2'd0,
      tx_sending = 2'd1,
      tx_done    = 2'd2,
      tx_error   = 2'd3
   } tx_result_t;

   // one byte as delivered by the udp receive path
   typedef struct packed {
      logic [7:0]  data;
      logic        valid;
      logic        last;
      logic        start;
      logic [15:0] dst_port;
      logic [15:0] src_port;
      logic [31:0] src_ip;
   } udp_rx_beat_t;

   typedef struct packed {
      logic [7:0] data;
      logic       valid;
      logic       last;
      logic       start;
   } client_rx_t;

   typedef struct packed {
      logic        start;
      logic [7:0]  data;
      logic        valid;
      logic        last;
      logic [15:0] length;
      logic [15:0] dst_port;
      logic [31:0] dst_ip;
   } client_tx_req_t;

   typedef struct packed {
      logic       grant;
      logic       ready;
      tx_result_t result;
   } client_tx_rsp_t;

   // request fields plus the source port the hub inserts
   typedef struct packed {
      logic        start;
      logic [7:0]  data;
      logic        valid;
      logic        last;
      logic [15:0] length;
      logic [15:0] dst_port;
      logic [31:0] dst_ip;
      logic [15:0] src_port;
   } udp_tx_t;

   typedef struct packed {
      logic [31:0] addr;
      logic        valid;
   } ip_lease_t;

   // port number owned by a client slot
   function automatic logic [15:0] client_port(input int unsigned idx);
      case (idx)
         client_dhcp:    return dhcp_client_port;
         client_control: return control_port;
         default:        return stream_port;
      endcase
   endfunction

endpackage

//--- source/udp_rx_port_demux.sv
module udp_rx_port_demux (
   input  logic                      m_axis_aclk,
   input  logic                      m_axis_aresetn,
   input  udp_hub_pkg::udp_rx_beat_t rx_beat,
   output udp_hub_pkg::client_rx_t   dhcp_rx,
   output udp_hub_pkg::client_rx_t   control_rx,
   output udp_hub_pkg::client_rx_t   stream_rx
);
   import udp_hub_pkg::*;

   logic [num_clients-1:0] port_hit;
   logic [num_clients-1:0] valid_q;
   logic [num_clients-1:0] last_q;
   logic [num_clients-1:0] start_q;
   logic [7:0]             data_q;

   // at most one slot matches since the ports are distinct
   always_comb begin
      for (int i = 0; i < num_clients; i++) begin
         port_hit[i] = (rx_beat.dst_port == client_port(i));
      end
   end

   // the byte itself is shared by every client
   always_ff @(posedge m_axis_aclk) begin
      data_q <= rx_beat.data;
   end

   always_ff @(posedge m_axis_aclk) begin
      if (!m_axis_aresetn) begin
         valid_q <= '0;
         last_q  <= '0;
         start_q <= '0;
      end else begin
         // beats for unknown ports leave every strobe low
         valid_q <= port_hit & {num_clients{rx_beat.valid}};
         last_q  <= port_hit & {num_clients{rx_beat.last}};
         start_q <= port_hit & {num_clients{rx_beat.start}};
      end
   end

   assign dhcp_rx = '{data: data_q, valid: valid_q[client_dhcp],
                      last: last_q[client_dhcp], start: start_q[client_dhcp]};

   assign control_rx = '{data: data_q, valid: valid_q[client_control],
                         last: last_q[client_control], start: start_q[client_control]};

   assign stream_rx = '{data: data_q, valid: valid_q[client_stream],
                        last: last_q[client_stream], start: start_q[client_stream]};

endmodule

//--- source/udp_tx_arbiter.sv
module udp_tx_arbiter (
   input  logic                        m_axis_aclk,
   input  logic                        m_axis_aresetn,
   input  udp_hub_pkg::client_tx_req_t dhcp_req,
   input  udp_hub_pkg::client_tx_req_t control_req,
   input  udp_hub_pkg::client_tx_req_t stream_req,
   input  logic                        tx_ready,
   input  udp_hub_pkg::tx_result_t     tx_result,
   output udp_hub_pkg::client_tx_rsp_t dhcp_rsp,
   output udp_hub_pkg::client_tx_rsp_t control_rsp,
   output udp_hub_pkg::client_tx_rsp_t stream_rsp,
   output udp_hub_pkg::udp_tx_t        tx
);
   import udp_hub_pkg::*;

   client_tx_req_t req [num_clients];
   client_tx_rsp_t rsp [num_clients];

   // one-hot and all zero while idle
   logic [num_clients-1:0] grant;
   logic [num_clients-1:0] start_vec;
   logic [num_clients-1:0] next_grant;
   logic                   release_grant;

   assign req[client_dhcp]    = dhcp_req;
   assign req[client_control] = control_req;
   assign req[client_stream]  = stream_req;

   assign dhcp_rsp    = rsp[client_dhcp];
   assign control_rsp = rsp[client_control];
   assign stream_rsp  = rsp[client_stream];

   always_comb begin
      for (int i = 0; i < num_clients; i++) begin
         start_vec[i] = req[i].start;
      end
   end

   // isolate the lowest set bit, which is the highest priority requester
   assign next_grant = start_vec & (~start_vec + 1'b1);

   // the transfer ends with either done or error from the stack
   assign release_grant = (tx_result == tx_done) || (tx_result == tx_error);

   always_ff @(posedge m_axis_aclk) begin
      if (!m_axis_aresetn) begin
         grant <= '0;
      end else if (grant == '0) begin
         grant <= next_grant;
      end else if (release_grant) begin
         // drop for one cycle before the next arbitration
         grant <= '0;
      end
   end

   // forward the granted request with nothing buffered in between
   always_comb begin
      tx = '0;
      for (int i = 0; i < num_clients; i++) begin
         if (grant[i]) begin
            tx.start    = req[i].start;
            tx.data     = req[i].data;
            tx.valid    = req[i].valid;
            tx.last     = req[i].last;
            tx.length   = req[i].length;
            tx.dst_port = req[i].dst_port;
            tx.dst_ip   = req[i].dst_ip;
            tx.src_port = client_port(i);
         end
      end
   end

   // ready and result are only visible to the owner of the grant
   always_comb begin
      for (int i = 0; i < num_clients; i++) begin
         rsp[i].grant  = grant[i];
         rsp[i].ready  = grant[i] & tx_ready;
         rsp[i].result = grant[i] ? tx_result : tx_idle;
      end
   end

endmodule

//--- source/dhcp_supervisor.sv
module dhcp_supervisor #(
   parameter int unsigned auto_dhcp_seconds = 8
) (
   input  logic                   m_axis_aclk,
   input  logic                   m_axis_aresetn,
   input  logic                   second_tick,
   input  logic                   do_dhcp,
   input  logic                   control_dhcp_reset,
   input  udp_hub_pkg::ip_lease_t dhcp_lease,
   input  udp_hub_pkg::ip_lease_t static_lease,
   input  udp_hub_pkg::ip_lease_t forced_lease,
   output logic                   dhcp_trigger,
   output logic                   dhcp_hold,
   output udp_hub_pkg::ip_lease_t my_ip
);

   localparam int unsigned count_w = $clog2(auto_dhcp_seconds + 1);

   logic [count_w-1:0] tick_count;
   logic [count_w-1:0] tick_count_next;
   logic               auto_done;
   logic               auto_fire;
   logic               force_ip;

   assign tick_count_next = tick_count + 1'b1;

   // the tick that brings the count up to the limit launches dhcp
   assign auto_fire = second_tick && !auto_done &&
                      (tick_count_next == count_w'(auto_dhcp_seconds));

   assign force_ip = forced_lease.valid;

   always_ff @(posedge m_axis_aclk) begin
      if (!m_axis_aresetn) begin
         tick_count <= '0;
         auto_done  <= 1'b0;
      end else begin
         if (second_tick && !auto_done) begin
            tick_count <= tick_count_next;
         end
         // counter stays frozen from here until the next reset
         if (auto_fire) begin
            auto_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge m_axis_aclk) begin
      if (!m_axis_aresetn) begin
         dhcp_trigger <= 1'b0;
         dhcp_hold    <= 1'b0;
      end else begin
         dhcp_trigger <= do_dhcp || auto_fire;
         // dhcp client sits in reset while another address source rules
         dhcp_hold    <= force_ip || control_dhcp_reset;
      end
   end

   // forced beats static, static beats the lease from dhcp
   always_ff @(posedge m_axis_aclk) begin
      if (force_ip) begin
         my_ip.addr <= forced_lease.addr;
      end else if (control_dhcp_reset) begin
         my_ip.addr <= static_lease.addr;
      end else begin
         my_ip.addr <= dhcp_lease.addr;
      end
   end

   always_ff @(posedge m_axis_aclk) begin
      if (!m_axis_aresetn) begin
         my_ip.valid <= 1'b0;
      end else if (force_ip) begin
         my_ip.valid <= 1'b1;
      end else if (control_dhcp_reset) begin
         my_ip.valid <= static_lease.valid;
      end else begin
         my_ip.valid <= dhcp_lease.valid;
      end
   end

endmodule

//--- source/udp_port_hub.sv
module udp_port_hub #(
   parameter int unsigned auto_dhcp_seconds = 8
) (
   input  logic                        m_axis_aclk,
   input  logic                        m_axis_aresetn,

   // udp stack side
   input  udp_hub_pkg::udp_rx_beat_t   rx_beat,
   output udp_hub_pkg::udp_tx_t        tx,
   input  logic                        tx_ready,
   input  udp_hub_pkg::tx_result_t     tx_result,

   // port clients, receive
   output udp_hub_pkg::client_rx_t     dhcp_rx,
   output udp_hub_pkg::client_rx_t     control_rx,
   output udp_hub_pkg::client_rx_t     stream_rx,

   // port clients, transmit
   input  udp_hub_pkg::client_tx_req_t dhcp_req,
   input  udp_hub_pkg::client_tx_req_t control_req,
   input  udp_hub_pkg::client_tx_req_t stream_req,
   output udp_hub_pkg::client_tx_rsp_t dhcp_rsp,
   output udp_hub_pkg::client_tx_rsp_t control_rsp,
   output udp_hub_pkg::client_tx_rsp_t stream_rsp,

   // address and dhcp supervision
   input  logic                        second_tick,
   input  logic                        do_dhcp,
   input  logic                        control_dhcp_reset,
   input  udp_hub_pkg::ip_lease_t      dhcp_lease,
   input  udp_hub_pkg::ip_lease_t      static_lease,
   input  udp_hub_pkg::ip_lease_t      forced_lease,
   output logic                        dhcp_trigger,
   output logic                        dhcp_hold,
   output udp_hub_pkg::ip_lease_t      my_ip
);

   udp_rx_port_demux rx_demux_inst (
      .m_axis_aclk    (m_axis_aclk),
      .m_axis_aresetn (m_axis_aresetn),
      .rx_beat        (rx_beat),
      .dhcp_rx        (dhcp_rx),
      .control_rx     (control_rx),
      .stream_rx      (stream_rx)
   );

   udp_tx_arbiter tx_arbiter_inst (
      .m_axis_aclk    (m_axis_aclk),
      .m_axis_aresetn (m_axis_aresetn),
      .dhcp_req       (dhcp_req),
      .control_req    (control_req),
      .stream_req     (stream_req),
      .tx_ready       (tx_ready),
      .tx_result      (tx_result),
      .dhcp_rsp       (dhcp_rsp),
      .control_rsp    (control_rsp),
      .stream_rsp     (stream_rsp),
      .tx             (tx)
   );

   // the trigger and hold outputs drive the external dhcp client
   dhcp_supervisor #(
      .auto_dhcp_seconds (auto_dhcp_seconds)
   ) dhcp_supervisor_inst (
      .m_axis_aclk        (m_axis_aclk),
      .m_axis_aresetn     (m_axis_aresetn),
      .second_tick        (second_tick),
      .do_dhcp            (do_dhcp),
      .control_dhcp_reset (control_dhcp_reset),
      .dhcp_lease         (dhcp_lease),
      .static_lease       (static_lease),
      .forced_lease       (forced_lease),
      .dhcp_trigger       (dhcp_trigger),
      .dhcp_hold          (dhcp_hold),
      .my_ip              (my_ip)
   );

endmodule

//--- tests/stack_model.sv
module stack_model #(
   parameter int seed_init = 33238
) (
   input  logic                    m_axis_aclk,
   input  logic                    m_axis_aresetn,
   input  udp_hub_pkg::udp_tx_t    tx,
   input  logic                    script_error,
   output logic                    tx_ready,
   output udp_hub_pkg::tx_result_t tx_result,
   output int                      byte_count
);
   timeunit 1ns;
   timeprecision 100ps;
   import udp_hub_pkg::*;

   integer seed;
   logic   frame_end;

   initial begin
      seed       = seed_init;
      tx_ready   = 1'b0;
      tx_result  = tx_idle;
      byte_count = 0;
      frame_end  = 1'b0;
      forever begin
         @(posedge m_axis_aclk);
         frame_end = 1'b0;
         // a byte moves when valid and ready meet at the edge
         if (m_axis_aresetn && tx.valid && tx_ready) begin
            byte_count++;
            frame_end = tx.last;
         end
         #1;
         if (!m_axis_aresetn) begin
            tx_ready  = 1'b0;
            tx_result = tx_idle;
         end else if (frame_end) begin
            // one result cycle closes the frame and accepts no byte
            tx_ready  = 1'b0;
            tx_result = script_error ? tx_error : tx_done;
         end else begin
            tx_ready  = ($random(seed) & 3) != 0;
            tx_result = tx_idle;
         end
      end
   end

endmodule

//--- tests/udp_port_hub_tb.sv
module udp_port_hub_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import udp_hub_pkg::*;

   localparam int auto_secs   = 3;
   localparam int demux_beats = 64;
   // random ready may cost up to four cycles a byte in each test budget
   localparam int len_reset = 6;
   localparam int len_demux = demux_beats + 4;
   localparam int len_prio  = 4 * (5 + 4) + 16;
   localparam int len_bp    = 4 * 12 + 10;
   localparam int len_route = 4 * (3 + 2) + 20;
   localparam int len_dhcp  = 5 * 5 + 12;
   localparam int len_addr  = 4 * 3 + 4;
   localparam int timeout_cycles =
      2 * (len_reset + len_demux + len_prio + len_bp + len_route + len_dhcp + len_addr);

   logic           clk = 1'b0;
   logic           rstn;
   udp_rx_beat_t   rx_beat;
   udp_tx_t        tx;
   logic           tx_ready;
   tx_result_t     tx_result;
   client_rx_t     rx_out [3];
   client_tx_req_t req [3];
   client_tx_rsp_t rsp [3];
   logic           second_tick;
   logic           do_dhcp;
   logic           control_dhcp_reset;
   ip_lease_t      dhcp_lease;
   ip_lease_t      static_lease;
   ip_lease_t      forced_lease;
   ip_lease_t      my_ip;
   logic           dhcp_trigger;
   logic           dhcp_hold;
   logic           script_error;
   int             byte_count;
   integer         seed;
   int             errors = 0;
   int             cycles = 0;
   int             trig_count = 0;
   int             grant_cycle [3];

   // expected state is updated at each rising edge
   logic           chk_en = 1'b0;
   logic [2:0]     ref_grant;
   client_rx_t     ref_rx [3];
   int             ref_ticks;
   logic           ref_auto_done;
   logic           ref_trigger;
   logic           ref_hold;
   ip_lease_t      ref_ip;
   logic           auto_fire;

   always #5 clk = ~clk;

   udp_port_hub #(
      .auto_dhcp_seconds (auto_secs)
   ) udp_port_hub_inst (
      .m_axis_aclk        (clk),
      .m_axis_aresetn     (rstn),
      .rx_beat            (rx_beat),
      .tx                 (tx),
      .tx_ready           (tx_ready),
      .tx_result          (tx_result),
      .dhcp_rx            (rx_out[0]),
      .control_rx         (rx_out[1]),
      .stream_rx          (rx_out[2]),
      .dhcp_req           (req[0]),
      .control_req        (req[1]),
      .stream_req         (req[2]),
      .dhcp_rsp           (rsp[0]),
      .control_rsp        (rsp[1]),
      .stream_rsp         (rsp[2]),
      .second_tick        (second_tick),
      .do_dhcp            (do_dhcp),
      .control_dhcp_reset (control_dhcp_reset),
      .dhcp_lease         (dhcp_lease),
      .static_lease       (static_lease),
      .forced_lease       (forced_lease),
      .dhcp_trigger       (dhcp_trigger),
      .dhcp_hold          (dhcp_hold),
      .my_ip              (my_ip)
   );

   stack_model #(
      .seed_init (33238)
   ) stack_model_inst (
      .m_axis_aclk    (clk),
      .m_axis_aresetn (rstn),
      .tx             (tx),
      .script_error   (script_error),
      .tx_ready       (tx_ready),
      .tx_result      (tx_result),
      .byte_count     (byte_count)
   );

   function automatic string client_name(input int idx);
      case (idx)
         0:       return "dhcp";
         1:       return "control";
         default: return "stream";
      endcase
   endfunction

   function automatic logic [15:0] port_of(input int idx);
      case (idx)
         0:       return 16'd68;
         1:       return 16'd18521;
         default: return 16'd18520;
      endcase
   endfunction

   function automatic client_rx_t expected_rx(input udp_rx_beat_t b, input int idx);
      client_rx_t e;
      logic       hit;
      hit     = (b.dst_port == port_of(idx));
      e.data  = b.data;
      e.valid = hit & b.valid;
      e.last  = hit & b.last;
      e.start = hit & b.start;
      return e;
   endfunction

   // lowest index wins
   function automatic logic [2:0] lowest_grant(input logic [2:0] starts);
      if (starts[0]) begin
         return 3'b001;
      end else if (starts[1]) begin
         return 3'b010;
      end else if (starts[2]) begin
         return 3'b100;
      end
      return 3'b000;
   endfunction

   function automatic udp_tx_t expected_tx(input logic [2:0] g, input client_tx_req_t r0,
                                           input client_tx_req_t r1, input client_tx_req_t r2);
      udp_tx_t        e;
      client_tx_req_t r;
      int             idx;
      e = '0;
      if (g != 3'b000) begin
         idx        = g[0] ? 0 : (g[1] ? 1 : 2);
         r          = (idx == 0) ? r0 : ((idx == 1) ? r1 : r2);
         e.start    = r.start;
         e.data     = r.data;
         e.valid    = r.valid;
         e.last     = r.last;
         e.length   = r.length;
         e.dst_port = r.dst_port;
         e.dst_ip   = r.dst_ip;
         e.src_port = port_of(idx);
      end
      return e;
   endfunction

   function automatic ip_lease_t select_ip(input ip_lease_t dhcp, input ip_lease_t stat,
                                           input ip_lease_t forced, input logic ctrl_reset);
      ip_lease_t e;
      if (forced.valid) begin
         e.addr  = forced.addr;
         e.valid = 1'b1;
      end else if (ctrl_reset) begin
         e = stat;
      end else begin
         e = dhcp;
      end
      return e;
   endfunction

   task automatic report_mismatch(input string name, input logic [127:0] exp,
                                  input logic [127:0] act);
      $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
      errors++;
   endtask

   task automatic note_failure(input string what);
      $display("t=%0t %s", $time, what);
      errors++;
   endtask

   task automatic end_test(input string name, input int errs_before);
      int n;
      n = errors - errs_before;
      if (n == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, n);
      end
   endtask

   task automatic send_beats(input int n);
      udp_rx_beat_t b;
      int           sel;
      for (int k = 0; k < n; k++) begin
         sel        = $random(seed) & 3;
         b.data     = 8'($random(seed));
         b.valid    = ($random(seed) & 3) != 0;
         b.last     = 1'($random(seed));
         b.start    = 1'($random(seed));
         b.dst_port = (sel == 3) ? 16'd80 : port_of(sel);
         b.src_port = 16'($random(seed));
         b.src_ip   = $random(seed);
         @(posedge clk);
         #1;
         rx_beat = b;
      end
      @(posedge clk);
      #1;
      rx_beat = '0;
   endtask

   // one client frame goes through request, grant, data bytes and result
   task automatic send_frame(input int idx, input int len, output tx_result_t res);
      client_tx_req_t r;
      int             sent;
      logic           granted;
      logic           first_grant;
      sent       = 0;
      granted    = 1'b0;
      r.start    = 1'b1;
      r.data     = 8'($random(seed));
      r.valid    = 1'b1;
      r.last     = (len == 1);
      r.length   = 16'(len);
      r.dst_port = 16'($random(seed));
      r.dst_ip   = $random(seed);
      @(posedge clk);
      #1;
      req[idx] = r;
      while (sent < len) begin
         @(posedge clk);
         first_grant = rsp[idx].grant && !granted;
         if (first_grant) begin
            granted = 1'b1;
         end
         if (rsp[idx].ready && r.valid) begin
            sent++;
            r.data  = 8'($random(seed));
            r.last  = (sent == len - 1);
            r.valid = (sent < len);
         end
         #1;
         if (first_grant) begin
            grant_cycle[idx] = cycles;
         end
         if (granted) begin
            r.start = 1'b0;
         end
         req[idx] = r;
      end
      do begin
         @(posedge clk);
      end while (rsp[idx].result != tx_done && rsp[idx].result != tx_error);
      res = rsp[idx].result;
      #1;
      req[idx] = '0;
   endtask

   always @(posedge clk) begin
      if (!rstn) begin
         chk_en        = 1'b0;
         ref_grant     = 3'b000;
         ref_ticks     = 0;
         ref_auto_done = 1'b0;
      end else begin
         chk_en = 1'b1;
         for (int i = 0; i < 3; i++) begin
            ref_rx[i] = expected_rx(rx_beat, i);
         end
         // automatic start fires once per reset on the tick that reaches the limit
         auto_fire   = second_tick && !ref_auto_done && (ref_ticks + 1 == auto_secs);
         ref_trigger = do_dhcp || auto_fire;
         if (second_tick && !ref_auto_done) begin
            ref_ticks++;
         end
         if (auto_fire) begin
            ref_auto_done = 1'b1;
         end
         ref_hold = forced_lease.valid || control_dhcp_reset;
         ref_ip   = select_ip(dhcp_lease, static_lease, forced_lease, control_dhcp_reset);
         if (ref_grant == 3'b000) begin
            ref_grant = lowest_grant({req[2].start, req[1].start, req[0].start});
         end else if (tx_result == tx_done || tx_result == tx_error) begin
            ref_grant = 3'b000;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("Test failed");
         $finish;
      end
   end

   // outputs are settled mid-cycle
   always @(negedge clk) begin
      client_tx_rsp_t exp_rsp;
      udp_tx_t        exp_tx;
      if (chk_en) begin
         for (int i = 0; i < 3; i++) begin
            if (rx_out[i] !== ref_rx[i]) begin
               report_mismatch({client_name(i), "_rx"}, 128'(ref_rx[i]), 128'(rx_out[i]));
            end
            exp_rsp.grant  = ref_grant[i];
            exp_rsp.ready  = ref_grant[i] & tx_ready;
            exp_rsp.result = ref_grant[i] ? tx_result : tx_idle;
            if (rsp[i] !== exp_rsp) begin
               report_mismatch({client_name(i), "_rsp"}, 128'(exp_rsp), 128'(rsp[i]));
            end
         end
         exp_tx = expected_tx(ref_grant, req[0], req[1], req[2]);
         if (tx !== exp_tx) begin
            report_mismatch("tx", 128'(exp_tx), 128'(tx));
         end
         if (dhcp_trigger !== ref_trigger) begin
            report_mismatch("dhcp_trigger", 128'(ref_trigger), 128'(dhcp_trigger));
         end
         if (dhcp_hold !== ref_hold) begin
            report_mismatch("dhcp_hold", 128'(ref_hold), 128'(dhcp_hold));
         end
         if (my_ip !== ref_ip) begin
            report_mismatch("my_ip", 128'(ref_ip), 128'(my_ip));
         end
         if (dhcp_trigger) begin
            trig_count++;
         end
      end
   end

   initial begin
      int         mark;
      int         count0;
      tx_result_t res_a;
      tx_result_t res_b;
      seed    = 33238;
      rstn    = 1'b0;
      rx_beat = '0;
      for (int i = 0; i < 3; i++) begin
         req[i]         = '0;
         grant_cycle[i] = 0;
      end
      second_tick        = 1'b0;
      do_dhcp            = 1'b0;
      control_dhcp_reset = 1'b0;
      dhcp_lease         = '0;
      static_lease       = '0;
      forced_lease       = '0;
      script_error       = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;

      mark = errors;
      send_beats(demux_beats);
      repeat (2) @(posedge clk);
      end_test("demux", mark);

      // dhcp and stream ask in the same idle cycle
      mark   = errors;
      count0 = byte_count;
      fork
         send_frame(0, 5, res_a);
         send_frame(2, 4, res_b);
      join
      if (!(grant_cycle[0] < grant_cycle[2])) begin
         note_failure("stream was granted before dhcp");
      end
      if (res_a !== tx_done) begin
         report_mismatch("dhcp_rsp.result", 128'(tx_done), 128'(res_a));
      end
      if (res_b !== tx_done) begin
         report_mismatch("stream_rsp.result", 128'(tx_done), 128'(res_b));
      end
      if (byte_count - count0 != 9) begin
         report_mismatch("byte_count", 128'(9), 128'(byte_count - count0));
      end
      end_test("priority", mark);

      mark   = errors;
      count0 = byte_count;
      send_frame(1, 12, res_a);
      if (res_a !== tx_done) begin
         report_mismatch("control_rsp.result", 128'(tx_done), 128'(res_a));
      end
      if (byte_count - count0 != 12) begin
         report_mismatch("byte_count", 128'(12), 128'(byte_count - count0));
      end
      end_test("back-pressure", mark);

      // an error ends the grant and the next frame must still go through
      mark         = errors;
      script_error = 1'b1;
      send_frame(1, 3, res_a);
      script_error = 1'b0;
      send_frame(2, 2, res_b);
      if (res_a !== tx_error) begin
         report_mismatch("control_rsp.result", 128'(tx_error), 128'(res_a));
      end
      if (res_b !== tx_done) begin
         report_mismatch("stream_rsp.result", 128'(tx_done), 128'(res_b));
      end
      end_test("result routing", mark);

      mark   = errors;
      count0 = trig_count;
      for (int k = 0; k < 5; k++) begin
         @(posedge clk);
         #1;
         second_tick = 1'b1;
         @(posedge clk);
         #1;
         second_tick = 1'b0;
         repeat (3) @(posedge clk);
      end
      if (trig_count - count0 != 1) begin
         report_mismatch("auto dhcp_trigger pulses", 128'(1), 128'(trig_count - count0));
      end
      @(posedge clk);
      #1;
      do_dhcp = 1'b1;
      @(posedge clk);
      #1;
      do_dhcp = 1'b0;
      repeat (3) @(posedge clk);
      if (trig_count - count0 != 2) begin
         report_mismatch("dhcp_trigger pulses", 128'(2), 128'(trig_count - count0));
      end
      end_test("dhcp start", mark);

      // bit 0 of c forces and bit 1 drives the control reset
      mark = errors;
      for (int c = 0; c < 4; c++) begin
         @(posedge clk);
         #1;
         dhcp_lease.addr    = $random(seed);
         dhcp_lease.valid   = 1'($random(seed));
         static_lease.addr  = $random(seed);
         static_lease.valid = 1'($random(seed));
         forced_lease.addr  = $random(seed);
         forced_lease.valid = c[0];
         control_dhcp_reset = c[1];
         repeat (2) @(posedge clk);
      end
      #1;
      forced_lease       = '0;
      control_dhcp_reset = 1'b0;
      repeat (2) @(posedge clk);
      end_test("address", mark);

      repeat (2) @(posedge clk);
      $display("tests run: 6, errors: %0d", errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- sources.f
source/udp_hub_pkg.sv
source/udp_rx_port_demux.sv
source/udp_tx_arbiter.sv
source/dhcp_supervisor.sv
source/udp_port_hub.sv
tests/stack_model.sv
tests/udp_port_hub_tb.sv

//--- run.sh
#!/bin/sh
# build and run the hub testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module udp_port_hub_tb \
   -f sources.f --Mdir obj_dir -o sim \
   && ./obj_dir/sim | tee /dev/stderr | grep -qx "Test passed" \
   && echo "simulation ok" \
   || { echo "simulation not ok"; exit 1; }
